//--- files.f
+incdir+include
verilog/memSystemPkg.sv
verilog/accessHold.sv
verilog/dataCache.sv
verilog/blockMemory.sv
verilog/peripheralPort.sv
verilog/memSystem.sv
verif/clockGen.sv
verif/memSystemTb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/100ps
TOP       := memSystemTb
FILELIST  := files.f
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation FAILED
PASS_MSG  := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run ended without a result"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verif/memSystemTb.sv
`include "memSystem_config.svh"

module memSystemTb;
  timeunit 1ns;
  timeprecision 100ps;
  import memSystemPkg::*;

  localparam int addrBits     = `MS_RAM_BLOCK_WIDTH + `MS_BLOCK_WIDTH;
  localparam int requestCount = 200;
  localparam int missCost     = 2 * (`MS_MEM_LATENCY + 2);
  localparam int flushIdle    = 3 * missCost;
  localparam int cycleLimit   = 2 * (requestCount * missCost + 4 * flushIdle + 16);

  logic        clkIn;
  logic        resetIn;
  logic        clearIn;
  accessSize_t accessType;
  logic        readWriteIn;
  logic [31:0] dataAddrIn;
  logic [31:0] dataIn;
  logic [31:0] dataOut;
  logic        dataOutValid;
  logic        dataWriteSuc;

  logic [7:0]  memModel [2 ** addrBits]; // bytes keyed by aliased address
  logic [31:0] ioModel [`MS_IO_REG_COUNT];
  logic [31:0] expectData;
  logic        expectRead;
  logic        expectWrite;
  logic        expectOneCycle;
  int          cyclesSinceStrobe;
  int          cycleCount;
  int          errorCount;
  int          testErrors;
  int          testsRun;
  int          testsFailed;
  string       testName;

  clockGen clocks (.clkIn, .resetIn);

  memSystem DUT (
    .clkIn, .resetIn, .clearIn, .accessType, .readWriteIn, .dataAddrIn, .dataIn,
    .dataOut, .dataOutValid, .dataWriteSuc
  );

  function automatic int byteCount(accessSize_t size);
    case (size)
      sizeByte: return 1;
      sizeHalf: return 2;
      sizeWord: return 4;
      default:  return 0;
    endcase
  endfunction

  function automatic logic [31:0] byteMask(accessSize_t size);
    return 32'hffff_ffff >> (32 - 8 * byteCount(size));
  endfunction

  function automatic logic isIo(logic [31:0] address);
    return address[17:16] == `MS_IO_REGION;
  endfunction

  function automatic logic [31:0] modelValue(logic [31:0] address, accessSize_t size);
    logic [31:0] value;
    logic [31:0] byteAddr;
    if (isIo(address)) begin
      return ioModel[address[3:2]] & byteMask(size);
    end
    value = '0;
    for (int i = 0; i < byteCount(size); i++) begin
      byteAddr = address + 32'(i);
      value[8*i +: 8] = memModel[byteAddr[addrBits-1:0]];
    end
    return value; // zero-extended
  endfunction

  function automatic void modelWrite(logic [31:0] address, accessSize_t size, logic [31:0] data);
    logic [31:0] byteAddr;
    if (isIo(address)) begin
      ioModel[address[3:2]] = (ioModel[address[3:2]] & ~byteMask(size)) |
                              (data & byteMask(size));
    end else begin
      for (int i = 0; i < byteCount(size); i++) begin
        byteAddr = address + 32'(i);
        memModel[byteAddr[addrBits-1:0]] = data[8*i +: 8];
      end
    end
  endfunction

  function automatic logic [31:0] cacheableAddr();
    logic [31:0] address;
    address = $urandom;
    address[17] = 1'b0; // stays out of the i/o region
    return address;
  endfunction

  function automatic accessSize_t randomSize();
    return accessSize_t'(2'($urandom % 3) + 2'd1);
  endfunction

  task automatic doAccess(input accessSize_t size, input logic rw, input logic [31:0] address,
                          input logic [31:0] data, input logic oneCycle);
    expectData     = modelValue(address, size);
    expectRead     = rw;
    expectWrite    = !rw;
    expectOneCycle = oneCycle;
    @(posedge clkIn);
    #1;
    accessType  = size;
    readWriteIn = rw;
    dataAddrIn  = address;
    dataIn      = data;
    @(posedge clkIn);
    #1;
    accessType = sizeNone;
    @(negedge clkIn);
    while (!(dataOutValid || dataWriteSuc)) begin
      @(negedge clkIn);
    end
    @(posedge clkIn);
    #1;
    if (!rw) begin
      modelWrite(address, size, data);
    end
    expectRead     = 1'b0;
    expectWrite    = 1'b0;
    expectOneCycle = 1'b0;
  endtask

  // read strobe, then a wrong-prediction flush in the following cycle
  task automatic flushRead(input logic [31:0] address);
    @(posedge clkIn);
    #1;
    accessType  = sizeWord;
    readWriteIn = 1'b1;
    dataAddrIn  = address;
    @(posedge clkIn);
    #1;
    accessType = sizeNone;
    clearIn    = 1'b1;
    @(posedge clkIn);
    #1;
    clearIn = 1'b0;
    repeat (flushIdle) @(posedge clkIn);
  endtask

  task automatic beginTest(input string name);
    testName   = name;
    testErrors = errorCount;
  endtask

  task automatic endTest();
    testsRun++;
    if (errorCount == testErrors) begin
      $display("%s: ok", testName);
    end else begin
      testsFailed++;
      $display("%s: %0d errors", testName, errorCount - testErrors);
    end
  endtask

  always_ff @(posedge clkIn) begin
    if (accessType != sizeNone) begin
      cyclesSinceStrobe <= 1;
    end else begin
      cyclesSinceStrobe <= cyclesSinceStrobe + 1;
    end
  end

  // outputs are settled at the falling edge
  readValue: assert property (@(negedge clkIn) disable iff (resetIn)
    (dataOutValid && expectRead) |-> (dataOut == expectData))
    else begin
      errorCount++;
      $display("error %s: read data expected %h actual %h", testName, expectData, dataOut);
    end

  readExpected: assert property (@(negedge clkIn) disable iff (resetIn)
    dataOutValid |-> expectRead)
    else begin
      errorCount++;
      $display("%s: read response arrived with no read outstanding", testName);
    end

  writeExpected: assert property (@(negedge clkIn) disable iff (resetIn)
    dataWriteSuc |-> expectWrite)
    else begin
      errorCount++;
      $display("%s: write response arrived with no write outstanding", testName);
    end

  singleResponse: assert property (@(negedge clkIn) disable iff (resetIn)
    !(dataOutValid && dataWriteSuc))
    else begin
      errorCount++;
      $display("%s: read and write responses high in the same cycle", testName);
    end

  hitLatency: assert property (@(negedge clkIn) disable iff (resetIn)
    ((dataOutValid || dataWriteSuc) && expectOneCycle) |-> (cyclesSinceStrobe == 1))
    else begin
      errorCount++;
      $display("error %s: response latency expected 1 actual %0d", testName, cyclesSinceStrobe);
    end

  task automatic writeReadBack();
    logic [31:0] address;
    beginTest("writeReadBack");
    repeat (16) begin
      address = cacheableAddr() & ~32'h3;
      doAccess(sizeWord, 1'b0, address, $urandom, 1'b0);
      doAccess(sizeWord, 1'b1, address, 32'h0, 1'b1);
    end
    endTest();
  endtask

  task automatic subWordAccess();
    logic [31:0] base;
    logic [31:0] address;
    beginTest("subWordAccess");
    repeat (8) begin
      base = cacheableAddr() & ~32'h3;
      doAccess(sizeWord, 1'b0, base, $urandom, 1'b0);
      doAccess(sizeByte, 1'b0, base + ($urandom % 4), $urandom, 1'b1);
      doAccess(sizeHalf, 1'b0, base + ($urandom % 3), $urandom, 1'b1);
      doAccess(sizeWord, 1'b1, base, 32'h0, 1'b1);
      doAccess(randomSize(), 1'b1, base + ($urandom % 4), 32'h0, 1'b0);
    end
    repeat (8) begin
      address = (cacheableAddr() & ~32'hf) | (32'd13 + ($urandom % 3)); // near line end
      doAccess(($urandom % 2 == 0) ? sizeHalf : sizeWord, 1'b0, address, $urandom, 1'b0);
      doAccess(sizeWord, 1'b1, address, 32'h0, 1'b0);
      doAccess(sizeByte, 1'b1, address + 32'd3, 32'h0, 1'b0);
    end
    endTest();
  endtask

  task automatic conflictEviction();
    logic [31:0] addrA;
    logic [31:0] addrB;
    beginTest("conflictEviction");
    repeat (6) begin
      addrA = cacheableAddr() & ~32'h3;
      addrB = addrA ^ 32'h0000_0200; // same index, other tag and ram row
      doAccess(sizeWord, 1'b0, addrA, $urandom, 1'b0);
      doAccess(sizeWord, 1'b0, addrB, $urandom, 1'b0);
      doAccess(sizeWord, 1'b1, addrA, 32'h0, 1'b0);
      doAccess(sizeWord, 1'b1, addrB, 32'h0, 1'b0);
    end
    endTest();
  endtask

  task automatic hitTiming();
    logic [31:0] address;
    beginTest("hitTiming");
    repeat (8) begin
      address = (cacheableAddr() & ~32'hf) | (($urandom % 4) << 2);
      doAccess(sizeWord, 1'b1, address, 32'h0, 1'b0);
      doAccess(sizeWord, 1'b1, address, 32'h0, 1'b1);
      doAccess(randomSize(), 1'b0, address, $urandom, 1'b1);
      doAccess(sizeWord, 1'b1, address, 32'h0, 1'b1);
    end
    endTest();
  endtask

  task automatic ioRegisters();
    logic [31:0] address;
    beginTest("ioRegisters");
    repeat (12) begin
      address = $urandom | 32'h0003_0000;
      doAccess(randomSize(), 1'b0, address, $urandom, 1'b1);
      doAccess(randomSize(), 1'b1, address ^ ($urandom & 32'h0000_000c), 32'h0, 1'b1);
    end
    doAccess(sizeWord, 1'b0, address & ~32'h0001_0000, $urandom, 1'b0);
    doAccess(sizeWord, 1'b1, address, 32'h0, 1'b1);
    doAccess(sizeWord, 1'b1, address & ~32'h0001_0000, 32'h0, 1'b0);
    endTest();
  endtask

  task automatic flushTest();
    logic [31:0] address;
    beginTest("flushTest");
    repeat (4) begin
      address = cacheableAddr() & ~32'h3;
      doAccess(sizeWord, 1'b0, address, $urandom, 1'b0);
      flushRead(address ^ 32'h0000_0400); // conflicts with the line just written
      doAccess(sizeWord, 1'b1, address ^ 32'h0000_0400, 32'h0, 1'b0);
    end
    endTest();
  endtask

  initial begin
    void'($urandom(32'h1136e360));
    clearIn        = 1'b0;
    accessType     = sizeNone;
    readWriteIn    = 1'b0;
    dataAddrIn     = '0;
    dataIn         = '0;
    expectData     = '0;
    expectRead     = 1'b0;
    expectWrite    = 1'b0;
    expectOneCycle = 1'b0;
    testName       = "reset";
    foreach (memModel[i]) memModel[i] = 8'h00;
    foreach (ioModel[i]) ioModel[i] = 32'h0;
    @(negedge resetIn);
    @(posedge clkIn);
    writeReadBack();
    subWordAccess();
    conflictEviction();
    hitTiming();
    ioRegisters();
    flushTest();
    $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clkIn);
      cycleCount++;
    end
    $display("timeout: run did not finish within %0d cycles", cycleLimit);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- verif/clockGen.sv
module clockGen (
  output logic clkIn,
  output logic resetIn
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int resetCycles = 16;

  initial begin
    clkIn = 1'b0;
    forever #4 clkIn = ~clkIn; // 8 ns period
  end

  initial begin
    resetIn = 1'b1;
    repeat (resetCycles) @(posedge clkIn);
    #1 resetIn = 1'b0;
  end

endmodule

//--- verilog/memSystem.sv
`include "memSystem_config.svh"

module memSystem (
  input  logic                      clkIn,
  input  logic                      resetIn,
  input  logic                      clearIn,
  input  memSystemPkg::accessSize_t accessType,
  input  logic                      readWriteIn,
  input  logic [31:0]               dataAddrIn,
  input  logic [31:0]               dataIn,
  output logic [31:0]               dataOut,
  output logic                      dataOutValid,
  output logic                      dataWriteSuc
);
  import memSystemPkg::*;

  accessSize_t               reqType;
  logic                      reqReadWrite;
  memAddr_u                  reqAddr;
  logic [31:0]               reqData;
  logic                      ioSelect;
  logic                      accessDone;
  logic                      ioDone;
  logic                      miss;
  logic [31:`MS_BLOCK_WIDTH] missAddr;
  logic                      readWriteOut;
  lineData_t                 writeBackOut;
  logic                      memDataValid;
  logic [31:`MS_BLOCK_WIDTH] memAddr;
  lineData_t                 memDataIn;
  logic                      acceptWrite;
  logic [31:0]               cacheDataOut;
  logic                      cacheOutValid;
  logic                      cacheWriteSuc;

  accessHold u_accessHold (
    .clkIn, .resetIn, .clearIn, .accessType, .readWriteIn, .dataAddrIn, .dataIn,
    .accessDone, .ioDone, .reqType, .reqReadWrite, .reqAddr, .reqData, .ioSelect
  );

  dataCache u_dataCache (
    .clkIn, .resetIn, .reqType, .reqReadWrite, .reqAddr, .reqData, .ioSelect,
    .memDataValid, .memAddr, .memDataIn, .acceptWrite,
    .miss, .missAddr, .readWriteOut, .writeBackOut,
    .cacheDataOut, .cacheOutValid, .cacheWriteSuc, .accessDone
  );

  blockMemory u_blockMemory (
    .clkIn, .resetIn, .miss, .missAddr, .readWriteOut, .writeBackOut,
    .memDataValid, .memAddr, .memDataIn, .acceptWrite
  );

  peripheralPort u_peripheralPort (
    .clkIn, .resetIn, .reqType, .reqReadWrite, .reqAddr, .reqData, .ioSelect,
    .cacheDataOut, .cacheOutValid, .cacheWriteSuc,
    .ioDone, .dataOut, .dataOutValid, .dataWriteSuc
  );

endmodule

//--- verilog/peripheralPort.sv
`include "memSystem_config.svh"

module peripheralPort (
  input  logic                      clkIn,
  input  logic                      resetIn,
  input  memSystemPkg::accessSize_t reqType,
  input  logic                      reqReadWrite,
  input  memSystemPkg::memAddr_u    reqAddr,
  input  logic [31:0]               reqData,
  input  logic                      ioSelect,
  input  logic [31:0]               cacheDataOut,
  input  logic                      cacheOutValid,
  input  logic                      cacheWriteSuc,
  output logic                      ioDone,
  output logic [31:0]               dataOut,
  output logic                      dataOutValid,
  output logic                      dataWriteSuc
);
  import memSystemPkg::*;

  logic [31:0] ioReg [`MS_IO_REG_COUNT];
  logic [31:0] accessMask;
  logic [31:0] ioReadData;
  logic        ioReadValid;
  logic        ioWriteSuc;
  logic [$clog2(`MS_IO_REG_COUNT)-1:0] regSel;

  assign regSel     = reqAddr.io.regSel;
  assign accessMask = sizeMask(reqType);
  assign ioDone     = ioSelect; // accepted in the strobe cycle

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      ioReadValid <= 1'b0;
      ioWriteSuc  <= 1'b0;
      for (int i = 0; i < `MS_IO_REG_COUNT; i++) begin
        ioReg[i] <= 32'b0;
      end
    end else begin
      ioReadValid <= ioSelect && reqReadWrite;
      ioWriteSuc  <= ioSelect && !reqReadWrite;
      if (ioSelect && !reqReadWrite) begin
        ioReg[regSel] <= (ioReg[regSel] & ~accessMask) | (reqData & accessMask);
      end
    end
  end

  always_ff @(posedge clkIn) begin
    if (ioSelect && reqReadWrite) begin
      ioReadData <= ioReg[regSel] & accessMask;
    end
  end

  // only one side answers in any cycle
  assign dataOut      = ioReadValid ? ioReadData : cacheDataOut;
  assign dataOutValid = ioReadValid | cacheOutValid;
  assign dataWriteSuc = ioWriteSuc | cacheWriteSuc;

endmodule

//--- verilog/blockMemory.sv
`include "memSystem_config.svh"

module blockMemory (
  input  logic                      clkIn,
  input  logic                      resetIn,
  input  logic                      miss,
  input  logic [31:`MS_BLOCK_WIDTH] missAddr,
  input  logic                      readWriteOut,
  input  memSystemPkg::lineData_t   writeBackOut,
  output logic                      memDataValid,
  output logic [31:`MS_BLOCK_WIDTH] memAddr,
  output memSystemPkg::lineData_t   memDataIn,
  output logic                      acceptWrite
);
  import memSystemPkg::*;

  localparam int ramLines  = 2 ** `MS_RAM_BLOCK_WIDTH;
  localparam int countBits = $clog2(`MS_MEM_LATENCY + 1);

  lineData_t ram [ramLines];

  logic                          busy;
  logic [countBits-1:0]          count;
  logic                          isFill;
  logic [31:`MS_BLOCK_WIDTH]     latchedAddr;
  lineData_t                     lineBuf;
  logic [`MS_RAM_BLOCK_WIDTH-1:0] missRow;
  logic [`MS_RAM_BLOCK_WIDTH-1:0] latchedRow;
  logic                          accept;
  logic                          done;

  // upper line address bits alias
  assign missRow    = missAddr[`MS_BLOCK_WIDTH+`MS_RAM_BLOCK_WIDTH-1:`MS_BLOCK_WIDTH];
  assign latchedRow = latchedAddr[`MS_BLOCK_WIDTH+`MS_RAM_BLOCK_WIDTH-1:`MS_BLOCK_WIDTH];

  assign accept = !busy && miss;
  assign done   = busy && (count == '0);

  assign memDataValid = done && isFill;
  assign acceptWrite  = done && !isFill;
  assign memAddr      = latchedAddr;
  assign memDataIn    = lineBuf;

  initial begin
    for (int i = 0; i < ramLines; i++) begin
      ram[i] = '0; // memory starts zeroed
    end
  end

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (accept) begin
      busy  <= 1'b1;
      count <= countBits'(`MS_MEM_LATENCY - 1);
    end else if (done) begin
      busy <= 1'b0;
    end else if (busy) begin
      count <= count - 1;
    end
  end

  always_ff @(posedge clkIn) begin
    if (accept) begin
      latchedAddr <= missAddr;
      isFill      <= readWriteOut;
      lineBuf     <= readWriteOut ? ram[missRow] : writeBackOut; // fill reads early
    end
  end

  always @(posedge clkIn) begin
    if (done && !isFill) begin
      ram[latchedRow] <= lineBuf;
    end
  end

  // every completion pulse lands the fixed delay after its acceptance
  pulseLatency: assert property (@(posedge clkIn) disable iff (resetIn)
    (memDataValid || acceptWrite) |-> $past(accept, `MS_MEM_LATENCY));

endmodule

//--- verilog/dataCache.sv
`include "memSystem_config.svh"

module dataCache (
  input  logic                      clkIn,
  input  logic                      resetIn,
  input  memSystemPkg::accessSize_t reqType,
  input  logic                      reqReadWrite,
  input  memSystemPkg::memAddr_u    reqAddr,
  input  logic [31:0]               reqData,
  input  logic                      ioSelect,
  input  logic                      memDataValid,
  input  logic [31:`MS_BLOCK_WIDTH] memAddr,
  input  memSystemPkg::lineData_t   memDataIn,
  input  logic                      acceptWrite,
  output logic                      miss,
  output logic [31:`MS_BLOCK_WIDTH] missAddr,
  output logic                      readWriteOut,
  output memSystemPkg::lineData_t   writeBackOut,
  output logic [31:0]               cacheDataOut,
  output logic                      cacheOutValid,
  output logic                      cacheWriteSuc,
  output logic                      accessDone
);
  import memSystemPkg::*;

  localparam int lineBytes  = 2 ** `MS_BLOCK_WIDTH;
  localparam int lineBits   = lineBytes * 8;
  localparam int cacheLines = 2 ** `MS_CACHE_WIDTH;
  localparam int tagBits    = 32 - `MS_CACHE_WIDTH - `MS_BLOCK_WIDTH;

  logic [cacheLines-1:0] cacheValid;
  logic [cacheLines-1:0] cacheDirty;
  logic [tagBits-1:0]    cacheTag  [cacheLines];
  lineData_t             cacheData [cacheLines];

  logic [`MS_CACHE_WIDTH-1:0] lineIdx;
  logic [`MS_CACHE_WIDTH-1:0] nextIdx;
  logic [`MS_CACHE_WIDTH-1:0] missIdx;
  logic [tagBits-1:0]         nextTag;
  logic [tagBits-1:0]         missTag;
  logic                       active;
  logic                       nextLineUsed;
  logic                       hit;
  logic                       nextHit;
  logic                       lineReady;
  logic                       ready;
  logic                       needWriteBack;
  logic                       fillMatch;
  logic                       wbMatch;
  logic [31:0]                accessMask;
  logic [`MS_BLOCK_WIDTH+2:0] bitShift;
  logic [2*lineBits-1:0]      linePair;
  logic [2*lineBits-1:0]      shiftMask;
  logic [2*lineBits-1:0]      shiftData;
  logic [2*lineBits-1:0]      mergedPair;
  logic [31:0]                readWord;

  assign lineIdx = reqAddr.cache.index;
  assign nextIdx = lineIdx + 1;
  assign nextTag = reqAddr.cache.tag + tagBits'(&lineIdx); // wraps past last line
  assign active  = (reqType != sizeNone) && !ioSelect;

  always_comb begin
    case (reqType)
      sizeWord: nextLineUsed = (reqAddr.cache.offset > lineBytes - 4);
      sizeHalf: nextLineUsed = (reqAddr.cache.offset == lineBytes - 1);
      default:  nextLineUsed = 1'b0;
    endcase
  end

  assign hit       = cacheValid[lineIdx] && (cacheTag[lineIdx] == reqAddr.cache.tag);
  assign nextHit   = cacheValid[nextIdx] && (cacheTag[nextIdx] == nextTag);
  assign lineReady = hit && (!nextLineUsed || nextHit);
  assign ready     = active && lineReady;
  assign accessDone = ready;

  // first line first, then the crossing line
  assign missIdx       = hit ? nextIdx : lineIdx;
  assign missTag       = hit ? nextTag : reqAddr.cache.tag;
  assign needWriteBack = cacheDirty[missIdx];

  assign miss         = active && !lineReady;
  assign readWriteOut = !needWriteBack;
  assign writeBackOut = cacheData[missIdx];
  assign missAddr     = needWriteBack ? {cacheTag[missIdx], missIdx} : {missTag, missIdx};

  // completions left over from a flushed request are dropped
  assign fillMatch = memDataValid && miss && !needWriteBack && (memAddr == missAddr);
  assign wbMatch   = acceptWrite && miss && needWriteBack && (memAddr == missAddr);

  // both lines side by side, shifted to the byte offset
  assign accessMask = sizeMask(reqType);
  assign bitShift   = {reqAddr.cache.offset, 3'b000};
  assign linePair   = {cacheData[nextIdx], cacheData[lineIdx]};
  assign readWord   = 32'(linePair >> bitShift) & accessMask;
  assign shiftMask  = {{(2*lineBits-32){1'b0}}, accessMask} << bitShift;
  assign shiftData  = {{(2*lineBits-32){1'b0}}, reqData} << bitShift;
  assign mergedPair = (linePair & ~shiftMask) | (shiftData & shiftMask);

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      cacheValid    <= '0;
      cacheDirty    <= '0;
      cacheOutValid <= 1'b0;
      cacheWriteSuc <= 1'b0;
    end else begin
      cacheOutValid <= ready && reqReadWrite;
      cacheWriteSuc <= ready && !reqReadWrite;
      if (fillMatch) begin
        cacheValid[missIdx] <= 1'b1; // victim already clean
      end
      if (wbMatch) begin
        cacheDirty[missIdx] <= 1'b0;
      end
      if (ready && !reqReadWrite) begin
        cacheDirty[lineIdx] <= 1'b1;
        if (nextLineUsed) begin
          cacheDirty[nextIdx] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clkIn) begin
    if (fillMatch) begin
      cacheTag[missIdx]  <= missTag;
      cacheData[missIdx] <= memDataIn;
    end
    if (ready && !reqReadWrite) begin
      cacheData[lineIdx] <= mergedPair[lineBits-1:0];
      if (nextLineUsed) begin
        cacheData[nextIdx] <= mergedPair[2*lineBits-1:lineBits];
      end
    end
    if (ready && reqReadWrite) begin
      cacheDataOut <= readWord; // zero-extended
    end
  end

  // a dirty line always holds valid data
  dirtyValid: assert property (@(posedge clkIn) disable iff (resetIn)
    (cacheDirty & ~cacheValid) == '0);

endmodule

//--- verilog/accessHold.sv
`include "memSystem_config.svh"

module accessHold (
  input  logic                      clkIn,
  input  logic                      resetIn,
  input  logic                      clearIn,
  input  memSystemPkg::accessSize_t accessType,
  input  logic                      readWriteIn,
  input  logic [31:0]               dataAddrIn,
  input  logic [31:0]               dataIn,
  input  logic                      accessDone,
  input  logic                      ioDone,
  output memSystemPkg::accessSize_t reqType,
  output logic                      reqReadWrite,
  output memSystemPkg::memAddr_u    reqAddr,
  output logic [31:0]               reqData,
  output logic                      ioSelect
);
  import memSystemPkg::*;

  accessSize_t heldType;
  logic        heldReadWrite;
  logic [31:0] heldAddr;
  logic [31:0] heldData;
  logic        strobe;
  accessSize_t mergedType;
  logic        flushRead;

  assign strobe       = (accessType != sizeNone);
  assign mergedType   = strobe ? accessType : heldType;
  assign reqReadWrite = strobe ? readWriteIn : heldReadWrite;
  assign reqAddr      = strobe ? dataAddrIn : heldAddr;
  assign reqData      = strobe ? dataIn : heldData;

  // wrong prediction kills a read but lets a write through
  assign flushRead = clearIn && (mergedType != sizeNone) && reqReadWrite;
  assign reqType   = flushRead ? sizeNone : mergedType;
  assign ioSelect  = (reqType != sizeNone) && (reqAddr.io.region == `MS_IO_REGION);

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      heldType <= sizeNone;
    end else if (flushRead || accessDone || ioDone) begin
      heldType <= sizeNone;
    end else begin
      heldType <= mergedType; // keeps pending request
    end
  end

  always_ff @(posedge clkIn) begin
    if (strobe) begin
      heldReadWrite <= readWriteIn;
      heldAddr      <= dataAddrIn;
      heldData      <= dataIn;
    end
  end

  // core waits for the response before the next strobe
  singleOutstanding: assert property (@(posedge clkIn) disable iff (resetIn)
    (heldType != sizeNone) |-> (accessType == sizeNone));

endmodule

//--- verilog/memSystemPkg.sv
package memSystemPkg;

  `include "memSystem_config.svh"

  typedef enum logic [1:0] {
    sizeNone = 2'b00,
    sizeByte = 2'b01,
    sizeHalf = 2'b10,
    sizeWord = 2'b11
  } accessSize_t;

  typedef struct packed {
    logic [31-`MS_CACHE_WIDTH-`MS_BLOCK_WIDTH:0] tag;
    logic [`MS_CACHE_WIDTH-1:0]                  index;
    logic [`MS_BLOCK_WIDTH-1:0]                  offset;
  } cacheAddr_t;

  typedef struct packed {
    logic [13:0] upper;
    logic [1:0]  region;
    logic [11:0] spare;
    logic [1:0]  regSel;
    logic [1:0]  byteSel;
  } ioAddr_t;

  typedef union packed {
    cacheAddr_t cache;
    ioAddr_t    io;
  } memAddr_u;

  typedef logic [(2 ** `MS_BLOCK_WIDTH) * 8 - 1:0] lineData_t;

  // low bytes covered by an access of this size
  function automatic logic [31:0] sizeMask(accessSize_t size);
    case (size)
      sizeByte: return 32'h0000_00ff;
      sizeHalf: return 32'h0000_ffff;
      sizeWord: return 32'hffff_ffff;
      default:  return 32'h0000_0000;
    endcase
  endfunction

endpackage

//--- include/memSystem_config.svh
`ifndef MEM_SYSTEM_CONFIG_SVH
`define MEM_SYSTEM_CONFIG_SVH

// cache geometry
`define MS_BLOCK_WIDTH 4
`define MS_CACHE_WIDTH 5

// backing memory of 256 lines of 16 bytes
`define MS_RAM_BLOCK_WIDTH 8
`define MS_MEM_LATENCY 4

// i/o window on address bits 17:16
`define MS_IO_REGION 2'd3
`define MS_IO_REG_COUNT 4

`endif
